// ==== logic/cartPkg.sv ====
/*
 * Types and helpers for the cartridge devices: the I/O port number,
 * the timer count and state, and the byte pattern held by the ROM.
 */
`default_nettype none

package cartPkg;

    typedef logic [7:0] ioPort_t;        // Low byte of ADDR in an I/O cycle
    typedef logic [6:0] timerCount_t;    // Timer count, read back in bits 6:0

    typedef enum logic [1:0] {
        IDLE,
        COUNTING,
        EXPIRED
    } timerState_e;

    // ROM contents, low address byte XOR high address byte
    function automatic msxBusPkg::data_t romPattern(input msxBusPkg::addr_t addr);
        return addr[7:0] ^ addr[15:8];
    endfunction

endpackage

`default_nettype wire

// ==== logic/expansionBus.sv ====
/*
 * Fans the primary cartridge bus out to the secondary slots and merges
 * their replies back. SLTSL_n and IORQ_n are gated per slot by the
 * enable mask. With UseFf set, the bus and the replies each pass
 * through one register stage; otherwise both paths are wires.
 */
`default_nettype none
`timescale 1ns/1ps

`include "msx_config.svh"

module expansionBus #(
    parameter bit UseFf = `USE_FF
) (
    input  wire                         CLK,
    input  wire                         RESET_n,
    input  wire                         BUS_RESET_n,
    input  wire  msxBusPkg::addr_t      ADDR,
    input  wire  msxBusPkg::data_t      DIN,
    input  wire                         RD_n,
    input  wire                         WR_n,
    input  wire                         MERQ_n,
    input  wire                         IORQ_n,
    input  wire                         SLTSL_n,
    input  wire                         CS1_n,
    input  wire                         CS2_n,
    input  wire  msxBusPkg::slotMask_t  slotEnable,
    input  wire  msxBusPkg::slotData_t  secDout,
    input  wire  msxBusPkg::slotMask_t  secBusdir_n,
    input  wire  msxBusPkg::slotMask_t  secInt_n,
    input  wire  msxBusPkg::slotMask_t  secWait_n,
    input  wire  msxBusPkg::data_t      localDout,
    input  wire                         localBusdir_n,
    output msxBusPkg::addr_t            busAddr,
    output msxBusPkg::data_t            busDin,
    output logic                        busRd_n,
    output logic                        busWr_n,
    output logic                        busMerq_n,
    output logic                        busCs1_n,
    output logic                        busCs2_n,
    output msxBusPkg::slotMask_t        secSltsl_n,
    output msxBusPkg::slotMask_t        secIorq_n,
    output msxBusPkg::data_t            DOUT,
    output logic                        BUSDIR_n,
    output logic                        INT_n,
    output logic                        WAIT_n
);
    import msxBusPkg::*;

    addr_t     nxtAddr;
    data_t     nxtDin;
    logic      nxtRd_n;
    logic      nxtWr_n;
    logic      nxtMerq_n;
    logic      nxtCs1_n;
    logic      nxtCs2_n;
    slotMask_t nxtSltsl_n;
    slotMask_t nxtIorq_n;
    data_t     sumDout;
    logic      sumBusdir_n;
    logic      sumInt_n;
    logic      sumWait_n;

    // Bus as the slots should see it, idle during bus reset
    always_comb begin
        if (!BUS_RESET_n) begin
            nxtAddr    = '0;
            nxtDin     = '0;
            nxtRd_n    = 1'b1;
            nxtWr_n    = 1'b1;
            nxtMerq_n  = 1'b1;
            nxtCs1_n   = 1'b1;
            nxtCs2_n   = 1'b1;
            nxtSltsl_n = '1;
            nxtIorq_n  = '1;
        end else begin
            nxtAddr    = ADDR;
            nxtDin     = DIN;
            nxtRd_n    = RD_n;
            nxtWr_n    = WR_n;
            nxtMerq_n  = MERQ_n;
            nxtCs1_n   = CS1_n;
            nxtCs2_n   = CS2_n;
            nxtSltsl_n = ~({`SLOT_COUNT{~SLTSL_n}} & slotEnable);   // Hidden slot stays high
            nxtIorq_n  = ~({`SLOT_COUNT{~IORQ_n}} & slotEnable);
        end
    end

    // Idle slots drive 0 and 1, so OR and AND give the merged reply
    always_comb begin
        sumDout     = localDout;
        sumBusdir_n = localBusdir_n & (&secBusdir_n);
        sumInt_n    = &secInt_n;
        sumWait_n   = &secWait_n;
        for (int i = 0; i < `SLOT_COUNT; i++) begin
            sumDout = sumDout | secDout[i];
        end
    end

    if (UseFf) begin : gReg
        always_ff @(posedge CLK or negedge RESET_n) begin
            if (!RESET_n) begin
                busAddr    <= '0;
                busDin     <= '0;
                busRd_n    <= 1'b1;
                busWr_n    <= 1'b1;
                busMerq_n  <= 1'b1;
                busCs1_n   <= 1'b1;
                busCs2_n   <= 1'b1;
                secSltsl_n <= '1;
                secIorq_n  <= '1;
            end else begin
                busAddr    <= nxtAddr;
                busDin     <= nxtDin;
                busRd_n    <= nxtRd_n;
                busWr_n    <= nxtWr_n;
                busMerq_n  <= nxtMerq_n;
                busCs1_n   <= nxtCs1_n;
                busCs2_n   <= nxtCs2_n;
                secSltsl_n <= nxtSltsl_n;
                secIorq_n  <= nxtIorq_n;
            end
        end

        always_ff @(posedge CLK or negedge RESET_n) begin
            if (!RESET_n) begin
                DOUT     <= '0;
                BUSDIR_n <= 1'b1;
                INT_n    <= 1'b1;
                WAIT_n   <= 1'b1;
            end else if (!BUS_RESET_n) begin   // Quiet primary while the MSX resets
                DOUT     <= '0;
                BUSDIR_n <= 1'b1;
                INT_n    <= 1'b1;
                WAIT_n   <= 1'b1;
            end else begin
                DOUT     <= sumDout;
                BUSDIR_n <= sumBusdir_n;
                INT_n    <= sumInt_n;
                WAIT_n   <= sumWait_n;
            end
        end
    end else begin : gWire
        assign busAddr    = nxtAddr;
        assign busDin     = nxtDin;
        assign busRd_n    = nxtRd_n;
        assign busWr_n    = nxtWr_n;
        assign busMerq_n  = nxtMerq_n;
        assign busCs1_n   = nxtCs1_n;
        assign busCs2_n   = nxtCs2_n;
        assign secSltsl_n = nxtSltsl_n;
        assign secIorq_n  = nxtIorq_n;
        assign DOUT       = sumDout;
        assign BUSDIR_n   = sumBusdir_n;
        assign INT_n      = sumInt_n;
        assign WAIT_n     = sumWait_n;
    end

endmodule

`default_nettype wire

// ==== logic/ioTimerDevice.sv ====
/*
 * I/O countdown timer. Writing N to the timer port starts a count
 * that drops by one on each CLK_EN; at 0 the timer expires and pulls
 * int_n low. A read returns {expired, count} and, once the read ends,
 * clears the interrupt and returns the timer to idle.
 */
`default_nettype none
`timescale 1ns/1ps

`include "msx_config.svh"

module ioTimerDevice (
    input  wire                     CLK,
    input  wire                     RESET_n,
    input  wire                     CLK_EN,
    input  wire  msxBusPkg::addr_t  busAddr,
    input  wire  msxBusPkg::data_t  busDin,
    input  wire                     busRd_n,
    input  wire                     busWr_n,
    input  wire                     secIorq_n,
    output msxBusPkg::data_t        dout,
    output logic                    busdir_n,
    output logic                    int_n
);
    import cartPkg::*;

    ioPort_t     port;
    timerState_e state;
    timerCount_t count;
    logic        ioSel;
    logic        rdSel;
    logic        rdPrev;     // Timer read active last cycle
    logic        wrPrev;

    assign port  = busAddr[7:0];
    assign ioSel = !secIorq_n && (port == `TIMER_PORT);
    assign rdSel = ioSel && !busRd_n;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            state  <= IDLE;
            count  <= '0;
            rdPrev <= 1'b0;
            wrPrev <= 1'b1;
        end else begin
            rdPrev <= rdSel;
            wrPrev <= busWr_n;
            if (ioSel && !busWr_n && wrPrev) begin
                count <= busDin[6:0];
                state <= (busDin[6:0] == '0) ? EXPIRED : COUNTING;
            end else if (rdPrev && !rdSel) begin
                state <= IDLE;           // Status was read, acknowledge
            end else if (state == COUNTING && CLK_EN) begin
                count <= count - 1'b1;
                if (count == 7'd1) begin
                    state <= EXPIRED;
                end
            end
        end
    end

    assign int_n    = (state != EXPIRED);
    assign busdir_n = !rdSel;
    assign dout     = rdSel ? {state == EXPIRED, count} : '0;

endmodule

`default_nettype wire

// ==== logic/msxBusPkg.sv ====
/*
 * Cartridge bus types shared by the expander, the slot register and
 * the devices. Per-slot strobes and data are packed so that one port
 * carries all secondary slots.
 */
`default_nettype none

`include "msx_config.svh"

package msxBusPkg;

    typedef logic [15:0] addr_t;     // Z80 address bus
    typedef logic [7:0]  data_t;     // One data byte

    // One bit per secondary slot
    typedef logic [`SLOT_COUNT-1:0] slotMask_t;

    // DOUT of every secondary slot, slot 0 in the low byte
    typedef data_t [`SLOT_COUNT-1:0] slotData_t;

endpackage

`default_nettype wire

// ==== logic/msxSlotExpander.sv ====
/*
 * Top of the slot expander. The slot register and the expander sit
 * on the primary bus; slot 0 holds the pattern ROM, slot 1 the RAM
 * and slot 2 the I/O timer.
 */
`default_nettype none
`timescale 1ns/1ps

`include "msx_config.svh"

module msxSlotExpander (
    input  wire                     CLK,
    input  wire                     RESET_n,
    input  wire                     BUS_RESET_n,
    input  wire                     CLK_EN,
    input  wire  msxBusPkg::addr_t  ADDR,
    input  wire  msxBusPkg::data_t  DIN,
    input  wire                     RD_n,
    input  wire                     WR_n,
    input  wire                     MERQ_n,
    input  wire                     IORQ_n,
    input  wire                     SLTSL_n,
    input  wire                     CS1_n,
    input  wire                     CS2_n,
    output msxBusPkg::data_t        DOUT,
    output logic                    BUSDIR_n,
    output logic                    INT_n,
    output logic                    WAIT_n
);
    import msxBusPkg::*;

    addr_t     busAddr;
    data_t     busDin;
    logic      busRd_n;
    logic      busWr_n;
    logic      busMerq_n;
    logic      busCs1_n;
    slotMask_t secSltsl_n;
    slotMask_t secIorq_n;
    slotMask_t slotEnable;
    slotMask_t secBusdir_n;
    slotMask_t secInt_n;
    slotData_t secDout;
    data_t     localDout;
    logic      localBusdir_n;
    logic      timerInt_n;

    // Only the timer interrupts
    assign secInt_n = {timerInt_n, {(`SLOT_COUNT-1){1'b1}}};

    slotSelectRegs u_slotSelectRegs (
        .CLK(CLK), .RESET_n(RESET_n), .ADDR(ADDR), .DIN(DIN),
        .RD_n(RD_n), .WR_n(WR_n), .IORQ_n(IORQ_n),
        .slotEnable(slotEnable), .localDout(localDout), .localBusdir_n(localBusdir_n)
    );

    expansionBus #(.UseFf(`USE_FF)) u_expansionBus (
        .CLK(CLK), .RESET_n(RESET_n), .BUS_RESET_n(BUS_RESET_n),
        .ADDR(ADDR), .DIN(DIN), .RD_n(RD_n), .WR_n(WR_n), .MERQ_n(MERQ_n),
        .IORQ_n(IORQ_n), .SLTSL_n(SLTSL_n), .CS1_n(CS1_n), .CS2_n(CS2_n),
        .slotEnable(slotEnable), .secDout(secDout), .secBusdir_n(secBusdir_n),
        .secInt_n(secInt_n), .secWait_n('1),          // No device ever waits
        .localDout(localDout), .localBusdir_n(localBusdir_n),
        .busAddr(busAddr), .busDin(busDin), .busRd_n(busRd_n), .busWr_n(busWr_n),
        .busMerq_n(busMerq_n), .busCs1_n(busCs1_n),
        .busCs2_n(),                                  // RAM decodes its own window
        .secSltsl_n(secSltsl_n), .secIorq_n(secIorq_n),
        .DOUT(DOUT), .BUSDIR_n(BUSDIR_n), .INT_n(INT_n), .WAIT_n(WAIT_n)
    );

    romCartridge u_romCartridge (
        .CLK(CLK), .RESET_n(RESET_n), .busAddr(busAddr), .busRd_n(busRd_n),
        .busMerq_n(busMerq_n), .busCs1_n(busCs1_n), .secSltsl_n(secSltsl_n[0]),
        .dout(secDout[0]), .busdir_n(secBusdir_n[0])
    );

    ramCartridge u_ramCartridge (
        .CLK(CLK), .RESET_n(RESET_n), .busAddr(busAddr), .busDin(busDin),
        .busRd_n(busRd_n), .busWr_n(busWr_n), .busMerq_n(busMerq_n),
        .secSltsl_n(secSltsl_n[1]), .dout(secDout[1]), .busdir_n(secBusdir_n[1])
    );

    ioTimerDevice u_ioTimerDevice (
        .CLK(CLK), .RESET_n(RESET_n), .CLK_EN(CLK_EN), .busAddr(busAddr),
        .busDin(busDin), .busRd_n(busRd_n), .busWr_n(busWr_n),
        .secIorq_n(secIorq_n[2]), .dout(secDout[2]), .busdir_n(secBusdir_n[2]),
        .int_n(timerInt_n)
    );

endmodule

`default_nettype wire

// ==== logic/msx_config.svh ====
/*
 * Build-time settings for the MSX slot expander.
 * Include wherever a slot count, I/O port number, RAM depth or
 * register-stage choice is needed.
 */
`ifndef MSX_CONFIG_SVH
`define MSX_CONFIG_SVH

// Secondary slots behind the expander
`define SLOT_COUNT 3

// 1 puts a register stage on the bus and on the replies, 0 makes both wires
`define USE_FF 1

// I/O ports, matched against ADDR[7:0]
`define SLOT_CFG_PORT 8'hF0
`define TIMER_PORT 8'hF4

// RAM depth is 2**RAM_ADDR_BITS bytes, mirrored across its window
`define RAM_ADDR_BITS 8

`endif

// ==== logic/ramCartridge.sv ====
/*
 * Small RAM in page 2 (8000h to BFFFh), mirrored every
 * 2**RAM_ADDR_BITS bytes. Writes land once per write cycle on the
 * falling edge of WR_n; reads are answered straight from the array.
 */
`default_nettype none
`timescale 1ns/1ps

`include "msx_config.svh"

module ramCartridge (
    input  wire                     CLK,
    input  wire                     RESET_n,
    input  wire  msxBusPkg::addr_t  busAddr,
    input  wire  msxBusPkg::data_t  busDin,
    input  wire                     busRd_n,
    input  wire                     busWr_n,
    input  wire                     busMerq_n,
    input  wire                     secSltsl_n,
    output msxBusPkg::data_t        dout,
    output logic                    busdir_n
);
    import msxBusPkg::*;

    data_t                     mem [2**`RAM_ADDR_BITS];
    logic [`RAM_ADDR_BITS-1:0] idx;
    logic                      memSel;
    logic                      wrPrev;

    assign memSel = !secSltsl_n && !busMerq_n && (busAddr[15:14] == 2'b10);
    assign idx    = busAddr[`RAM_ADDR_BITS-1:0];      // Upper bits ignored, so it mirrors

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            wrPrev <= 1'b1;
        end else begin
            wrPrev <= busWr_n;
        end
    end

    always_ff @(posedge CLK) begin
        if (memSel && !busWr_n && wrPrev) begin
            mem[idx] <= busDin;
        end
    end

    assign busdir_n = !(memSel && !busRd_n);
    assign dout     = busdir_n ? '0 : mem[idx];

endmodule

`default_nettype wire

// ==== logic/romCartridge.sv ====
/*
 * Pattern ROM in page 1 (4000h to 7FFFh). A memory read selected by
 * SLTSL_n and CS1_n registers the byte for the address and drives it
 * with busdir_n low. Writes have no effect.
 */
`default_nettype none
`timescale 1ns/1ps

module romCartridge (
    input  wire                     CLK,
    input  wire                     RESET_n,
    input  wire  msxBusPkg::addr_t  busAddr,
    input  wire                     busRd_n,
    input  wire                     busMerq_n,
    input  wire                     busCs1_n,
    input  wire                     secSltsl_n,
    output msxBusPkg::data_t        dout,
    output logic                    busdir_n
);
    import cartPkg::*;

    logic romSel;

    // CS1_n already decodes the 4000h-7FFFh window
    assign romSel = !secSltsl_n && !busMerq_n && !busRd_n && !busCs1_n;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            dout     <= '0;
            busdir_n <= 1'b1;
        end else begin
            dout     <= romSel ? romPattern(busAddr) : '0;   // 0 when idle for the OR merge
            busdir_n <= !romSel;
        end
    end

endmodule

`default_nettype wire

// ==== logic/slotSelectRegs.sv ====
/*
 * I/O-mapped slot enable register. A write to the config port loads
 * one enable bit per secondary slot, a read returns the mask in the
 * low bits. Sits on the primary bus so it can never be hidden.
 */
`default_nettype none
`timescale 1ns/1ps

`include "msx_config.svh"

module slotSelectRegs (
    input  wire                      CLK,
    input  wire                      RESET_n,
    input  wire  msxBusPkg::addr_t   ADDR,
    input  wire  msxBusPkg::data_t   DIN,
    input  wire                      RD_n,
    input  wire                      WR_n,
    input  wire                      IORQ_n,
    output msxBusPkg::slotMask_t     slotEnable,
    output msxBusPkg::data_t         localDout,
    output logic                     localBusdir_n
);
    import msxBusPkg::*;
    import cartPkg::*;

    ioPort_t port;
    logic    portSel;
    logic    wrPrev;        // WR_n one cycle back

    assign port    = ADDR[7:0];
    assign portSel = !IORQ_n && (port == `SLOT_CFG_PORT);

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            wrPrev     <= 1'b1;
            slotEnable <= '1;       // All slots visible
        end else begin
            wrPrev <= WR_n;
            if (portSel && !WR_n && wrPrev) begin
                slotEnable <= DIN[`SLOT_COUNT-1:0];
            end
        end
    end

    // Read-back merges into the primary reply like a fourth slot
    assign localBusdir_n = !(portSel && !RD_n);
    assign localDout     = localBusdir_n ? '0 : data_t'(slotEnable);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Builds the slot expander testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f vlog.f --top-module tb_msxSlotExpander -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_msxSlotExpander 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation binary returned status $status"
    exit 1
fi

# Pass only when the testbench printed its pass line
if printf '%s\n' "$output" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1

// ==== test/busCycles.svh ====
/*
 * Primary bus cycles for the slot expander testbench. Included inside
 * the testbench module. Every task drives on the falling edge, holds
 * the access for HoldCycles, samples DOUT and BUSDIR_n at the end and
 * then leaves the bus idle for GapCycles.
 */
`ifndef BUS_CYCLES_SVH
`define BUS_CYCLES_SVH

task automatic busIdle();
    ADDR    = '0;
    DIN     = '0;
    RD_n    = 1'b1;
    WR_n    = 1'b1;
    MERQ_n  = 1'b1;
    IORQ_n  = 1'b1;
    SLTSL_n = 1'b1;
    CS1_n   = 1'b1;
    CS2_n   = 1'b1;
endtask

task automatic releaseBus();
    busIdle();
    repeat (GapCycles) @(negedge CLK);   // Replies drain through both stages
endtask

// Memory access in this cartridge slot, page selects decoded here
task automatic startMemCycle(input addr_t addr);
    @(negedge CLK);
    ADDR    = addr;
    CS1_n   = (addr[15:14] != 2'b01);
    CS2_n   = (addr[15:14] != 2'b10);
    SLTSL_n = 1'b0;
    MERQ_n  = 1'b0;
endtask

task automatic memRead(input addr_t addr, output data_t data, output logic busdir);
    startMemCycle(addr);
    RD_n = 1'b0;
    repeat (HoldCycles) @(negedge CLK);
    data   = DOUT;
    busdir = BUSDIR_n;
    releaseBus();
endtask

task automatic memWrite(input addr_t addr, input data_t data);
    startMemCycle(addr);
    DIN  = data;
    WR_n = 1'b0;
    repeat (HoldCycles) @(negedge CLK);
    releaseBus();
endtask

task automatic ioRead(input ioPort_t port, output data_t data, output logic busdir);
    @(negedge CLK);
    ADDR   = {8'h00, port};
    IORQ_n = 1'b0;
    RD_n   = 1'b0;
    repeat (HoldCycles) @(negedge CLK);
    data   = DOUT;
    busdir = BUSDIR_n;
    releaseBus();
endtask

task automatic ioWrite(input ioPort_t port, input data_t data);
    @(negedge CLK);
    ADDR   = {8'h00, port};
    DIN    = data;
    IORQ_n = 1'b0;
    WR_n   = 1'b0;
    repeat (HoldCycles) @(negedge CLK);
    releaseBus();
endtask

// One CLK_EN strobe, then a short pause
task automatic pulseClkEn();
    @(negedge CLK);
    CLK_EN = 1'b1;
    @(negedge CLK);
    CLK_EN = 1'b0;
    repeat (3) @(negedge CLK);
endtask

`endif

// ==== test/tb_msxSlotExpander.sv ====
/*
 * Testbench for the MSX slot expander. Runs memory and I/O cycles on
 * the primary bus and checks the merged replies against the ROM byte
 * rule, a local RAM model and the expected timer behaviour.
 */
`default_nettype none
`timescale 1ns/1ps

`include "msx_config.svh"

module tb_msxSlotExpander;
    import msxBusPkg::*;
    import cartPkg::*;

    localparam int HoldCycles   = 4;
    localparam int GapCycles    = 4;
    localparam int AccessCycles = 1 + HoldCycles + GapCycles;
    localparam int Accesses     = 75;   // ROM, RAM, timer and slot register cycles
    localparam int TestCycles   = 20 + AccessCycles * Accesses + 5 * 20;

    logic       CLK = 1'b0;
    logic       RESET_n;
    logic       BUS_RESET_n;
    logic       CLK_EN;
    addr_t      ADDR;
    data_t      DIN;
    logic       RD_n, WR_n, MERQ_n, IORQ_n, SLTSL_n, CS1_n, CS2_n;
    data_t      DOUT;
    logic       BUSDIR_n, INT_n, WAIT_n;
    int         errors = 0;
    int         checks = 0;
    data_t      ramModel [256];
    logic [7:0] writtenIdx [$];          // RAM offsets that hold known data

    msxSlotExpander u_msxSlotExpander (.*);

    always #5 CLK = ~CLK;

    `include "busCycles.svh"

    task automatic compareByte(input string name, input data_t expected, input data_t actual);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkLevel(input string name, input logic expected, input logic actual);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            $display("error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    initial begin
        #(2 * TestCycles * 10);
        $display("Watchdog expired after %0d cycles, test sequence did not finish",
                 2 * TestCycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        addr_t      addr;
        data_t      data;
        logic       busdir;
        logic [7:0] idx;
        int         n;
        int         k;

        void'($urandom(11));
        RESET_n     = 1'b0;
        BUS_RESET_n = 1'b1;
        CLK_EN      = 1'b0;
        busIdle();
        repeat (3) @(negedge CLK);
        RESET_n = 1'b1;
        repeat (2) @(negedge CLK);
        compareByte("reset DOUT", 8'h00, DOUT);
        checkLevel("reset BUSDIR_n", 1'b1, BUSDIR_n);
        checkLevel("reset INT_n", 1'b1, INT_n);
        checkLevel("reset WAIT_n", 1'b1, WAIT_n);

        // ROM read while the MSX holds the bus in reset
        BUS_RESET_n = 1'b0;
        memRead(16'h4321, data, busdir);
        compareByte("bus reset DOUT", 8'h00, data);
        checkLevel("bus reset BUSDIR_n", 1'b1, busdir);
        checkLevel("bus reset WAIT_n", 1'b1, WAIT_n);
        BUS_RESET_n = 1'b1;

        repeat (20) begin
            addr = addr_t'($urandom_range(16'h7FFF, 16'h4000));
            memRead(addr, data, busdir);
            compareByte("rom read DOUT", addr[7:0] ^ addr[15:8], data);
            checkLevel("rom read BUSDIR_n", 1'b0, busdir);
            checkLevel("rom idle BUSDIR_n", 1'b1, BUSDIR_n);
        end

        // Writes anywhere in page 2, reads back through other mirrors
        repeat (16) begin
            idx  = 8'($urandom());
            data = 8'($urandom());
            memWrite({2'b10, 6'($urandom()), idx}, data);
            ramModel[idx] = data;
            writtenIdx.push_back(idx);
        end
        foreach (writtenIdx[i]) begin
            idx = writtenIdx[i];
            memRead({2'b10, 6'($urandom()), idx}, data, busdir);
            compareByte("ram read DOUT", ramModel[idx], data);
            checkLevel("ram read BUSDIR_n", 1'b0, busdir);
        end

        n = $urandom_range(12, 6);
        k = $urandom_range(4, 1);
        ioWrite(`TIMER_PORT, data_t'(n));
        repeat (k) pulseClkEn();
        checkLevel("timer early INT_n", 1'b1, INT_n);
        ioRead(`TIMER_PORT, data, busdir);
        compareByte("timer early read", data_t'(n - k), data);

        n = $urandom_range(10, 3);
        ioWrite(`TIMER_PORT, data_t'(n));
        repeat (n) pulseClkEn();
        checkLevel("timer expired INT_n", 1'b0, INT_n);
        ioRead(`TIMER_PORT, data, busdir);
        compareByte("timer expired read", 8'h80, data);   // Status set, count 0
        checkLevel("timer read BUSDIR_n", 1'b0, busdir);
        checkLevel("timer cleared INT_n", 1'b1, INT_n);

        // Slot 0 hidden, RAM in slot 1 still visible
        ioWrite(`SLOT_CFG_PORT, 8'h06);
        ioRead(`SLOT_CFG_PORT, data, busdir);
        compareByte("slot mask read", 8'h06, data);
        memRead(addr_t'($urandom_range(16'h7FFF, 16'h4000)), data, busdir);
        compareByte("hidden rom DOUT", 8'h00, data);
        checkLevel("hidden rom BUSDIR_n", 1'b1, busdir);
        idx = writtenIdx[0];
        memRead({2'b10, 6'h3F, idx}, data, busdir);
        compareByte("ram with rom hidden", ramModel[idx], data);
        checkLevel("ram with rom hidden BUSDIR_n", 1'b0, busdir);

        ioWrite(`TIMER_PORT, 8'h05);      // Nonzero count that a visible timer would return
        ioWrite(`SLOT_CFG_PORT, 8'h03);   // Hide the timer
        ioRead(`SLOT_CFG_PORT, data, busdir);
        compareByte("slot mask read", 8'h03, data);
        ioRead(`TIMER_PORT, data, busdir);
        compareByte("hidden timer DOUT", 8'h00, data);
        checkLevel("hidden timer BUSDIR_n", 1'b1, busdir);
        ioWrite(`SLOT_CFG_PORT, 8'h07);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+logic
+incdir+test
logic/msxBusPkg.sv
logic/cartPkg.sv
logic/expansionBus.sv
logic/slotSelectRegs.sv
logic/romCartridge.sv
logic/ramCartridge.sv
logic/ioTimerDevice.sv
logic/msxSlotExpander.sv
test/tb_msxSlotExpander.sv
